// ==== bench/core_chk.sv ====
`timescale 1ns/100ps

module core_chk
    import core_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       inst_start,
    input logic       inst_ready,
    input word_t      i_addr,
    input logic       d_cmd_start,
    input logic       d_cmd_write,
    input logic       d_cmd_ready,
    input word_t      d_addr,
    input word_t      wdata,
    input byte_mask_t wmask
);

    // instruction request held until accepted
    assert property (@(posedge clk) disable iff (reset)
        inst_start && !inst_ready |=> inst_start && $stable(i_addr))
        else $error("instruction request dropped or changed before inst_ready");

    // data command and its fields held until accepted
    assert property (@(posedge clk) disable iff (reset)
        d_cmd_start && !d_cmd_ready |=> d_cmd_start && $stable(d_cmd_write)
            && $stable(d_addr) && $stable(wdata) && $stable(wmask))
        else $error("data command dropped or changed before d_cmd_ready");

    // quiet ports right after reset
    assert property (@(posedge clk) $fell(reset) |-> !inst_start && !d_cmd_start)
        else $error("memory request strobe high in the first cycle after reset");

endmodule

bind core core_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .inst_start  (inst_start),
    .inst_ready  (inst_ready),
    .i_addr      (i_addr),
    .d_cmd_start (d_cmd_start),
    .d_cmd_write (d_cmd_write),
    .d_cmd_ready (d_cmd_ready),
    .d_addr      (d_addr),
    .wdata       (wdata),
    .wmask       (wmask)
);

// ==== bench/core_tb.sv ====
`timescale 1ns/100ps

module core_tb
    import core_pkg::*;
();

    localparam int PROGRAM_LEN   = 44;
    localparam int NUM_STORES    = 14;
    localparam int STORE_TIMEOUT = 1000;
    localparam int SETTLE_CYCLES = 200;

    typedef struct packed {
        word_t      addr;
        byte_mask_t mask;
        word_t      data;
    } store_t;

    logic       clk;
    logic       reset;
    logic       inst_start;
    logic       inst_ready = 1'b0;
    word_t      i_addr;
    word_t      inst = '0;
    logic       inst_valid = 1'b0;
    logic       d_cmd_start;
    logic       d_cmd_write;
    logic       d_cmd_ready = 1'b0;
    word_t      d_addr;
    word_t      wdata;
    byte_mask_t wmask;
    word_t      rdata = '0;
    logic       rdata_valid = 1'b0;

    integer seed = 32'h2ef0_b6fa;
    int     errors;

    word_t  inst_mem [64];
    word_t  data_mem [64];
    store_t seen_stores [$];

    int         i_delay;
    logic       i_busy;
    logic [5:0] i_word;
    int         d_delay;
    logic       d_busy;
    logic [5:0] d_word;

    //********************
    // program and expected stores
    //********************

    word_t program_code [PROGRAM_LEN] = '{
        32'h1230_0093,  // 00 addi x1, x0, 0x123
        32'hffb0_0113,  // 04 addi x2, x0, -5
        32'habcd_e1b7,  // 08 lui  x3, 0xabcde
        32'h0f00_0213,  // 0c addi x4, x0, 0xf0
        32'h0aa0_0393,  // 10 addi x7, x0, 0xaa
        32'h0010_0413,  // 14 addi x8, x0, 1
        32'h0000_0013,  // 18 nop
        32'h0020_8533,  // 1c add  x10, x1, x2
        32'h4020_85b3,  // 20 sub  x11, x1, x2
        32'h0011_e633,  // 24 or   x12, x3, x1
        32'h0072_46b3,  // 28 xor  x13, x4, x7
        32'h0011_2733,  // 2c slt  x14, x2, x1
        32'h0f00_f793,  // 30 andi x15, x1, 0xf0
        32'h00f2_6813,  // 34 ori  x16, x4, 0xf
        32'hfff0_c893,  // 38 xori x17, x1, -1
        32'h1000_a913,  // 3c slti x18, x1, 0x100
        32'h04a0_2023,  // 40 sw x10, 0x40(x0)
        32'h04b0_2223,  // 44 sw x11, 0x44(x0)
        32'h04c0_2423,  // 48 sw x12, 0x48(x0)
        32'h04d0_2623,  // 4c sw x13, 0x4c(x0)
        32'h04e0_2823,  // 50 sw x14, 0x50(x0)
        32'h04f0_2a23,  // 54 sw x15, 0x54(x0)
        32'h0500_2c23,  // 58 sw x16, 0x58(x0)
        32'h0510_2e23,  // 5c sw x17, 0x5c(x0)
        32'h0720_2023,  // 60 sw x18, 0x60(x0)
        32'h0630_2223,  // 64 sw x3, 0x64(x0)
        32'h0480_2983,  // 68 lw x19, 0x48(x0)
        32'h0670_04a3,  // 6c sb x7, 0x69(x0)
        32'h0000_0013,  // 70 nop
        32'h0000_0013,  // 74 nop
        32'h0730_2623,  // 78 sw x19, 0x6c(x0)
        32'h0010_8663,  // 7c beq x1, x1, +12
        32'h0610_2823,  // 80 sw x1, 0x70(x0), skipped
        32'h0620_2a23,  // 84 sw x2, 0x74(x0), skipped
        32'h0084_1463,  // 88 bne x8, x8, +8
        32'h0680_2c23,  // 8c sw x8, 0x78(x0)
        32'h00c0_0a6f,  // 90 jal x20, +12
        32'h0610_2e23,  // 94 sw x1, 0x7c(x0), skipped
        32'h0620_2e23,  // 98 sw x2, 0x7c(x0), skipped
        32'h0000_0013,  // 9c nop
        32'h0000_0013,  // a0 nop
        32'h0000_0013,  // a4 nop
        32'h0940_2023,  // a8 sw x20, 0x80(x0)
        32'h0000_006f   // ac jal x0, 0
    };

    // address, mask, data in program order
    store_t expected_stores [NUM_STORES] = '{
        '{32'h0000_0040, 4'hf, 32'h0000_011e},
        '{32'h0000_0044, 4'hf, 32'h0000_0128},
        '{32'h0000_0048, 4'hf, 32'habcd_e123},
        '{32'h0000_004c, 4'hf, 32'h0000_005a},
        '{32'h0000_0050, 4'hf, 32'h0000_0001},
        '{32'h0000_0054, 4'hf, 32'h0000_0020},
        '{32'h0000_0058, 4'hf, 32'h0000_00ff},
        '{32'h0000_005c, 4'hf, 32'hffff_fedc},
        '{32'h0000_0060, 4'hf, 32'h0000_0000},
        '{32'h0000_0064, 4'hf, 32'habcd_e000},
        '{32'h0000_0068, 4'h2, 32'haaaa_aaaa},
        '{32'h0000_006c, 4'hf, 32'habcd_e123},
        '{32'h0000_0078, 4'hf, 32'h0000_0001},
        '{32'h0000_0080, 4'hf, 32'h0000_0094}
    };

    string test_names [NUM_STORES] = '{
        "add", "sub", "or", "xor", "slt", "andi", "ori", "xori", "slti", "lui",
        "sb", "sw_lw", "beq_bne", "jal_link"
    };

    core #(
        .RESET_PC(32'h0000_0000)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .inst_start  (inst_start),
        .inst_ready  (inst_ready),
        .i_addr      (i_addr),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .d_cmd_start (d_cmd_start),
        .d_cmd_write (d_cmd_write),
        .d_cmd_ready (d_cmd_ready),
        .d_addr      (d_addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int random_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    //********************
    // memory models
    //********************

    always @(posedge clk) begin
        inst_valid <= 1'b0;
        if (reset) begin
            inst_ready <= 1'b0;
            i_busy     <= 1'b0;
            i_delay    <= 0;
        end else if (i_busy) begin
            if (i_delay == 0) begin
                inst       <= inst_mem[i_word];
                inst_valid <= 1'b1;
                i_busy     <= 1'b0;
                i_delay    <= random_delay();
            end else begin
                i_delay <= i_delay - 1;
            end
        end else if (inst_start && inst_ready) begin
            inst_ready <= 1'b0;
            i_busy     <= 1'b1;
            i_word     <= i_addr[7:2];
            i_delay    <= random_delay();
        end else if (i_delay == 0) begin
            inst_ready <= 1'b1;
        end else begin
            i_delay <= i_delay - 1;
        end
    end

    always @(posedge clk) begin
        rdata_valid <= 1'b0;
        if (reset) begin
            d_cmd_ready <= 1'b0;
            d_busy      <= 1'b0;
            d_delay     <= 0;
            // fill from the byte address
            for (int w = 0; w < 64; w++) begin
                data_mem[w] <= 32'h5a5a_0000 ^ word_t'(w * 4);
            end
        end else if (d_busy) begin
            if (d_delay == 0) begin
                rdata       <= data_mem[d_word];
                rdata_valid <= 1'b1;
                d_busy      <= 1'b0;
                d_delay     <= random_delay();
            end else begin
                d_delay <= d_delay - 1;
            end
        end else if (d_cmd_start && d_cmd_ready) begin
            d_cmd_ready <= 1'b0;
            d_delay     <= random_delay();
            if (d_cmd_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (wmask[b]) begin
                        data_mem[d_addr[7:2]][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
                seen_stores.push_back({d_addr, wmask, wdata});
            end else begin
                d_busy <= 1'b1;
                d_word <= d_addr[7:2];
            end
        end else if (d_delay == 0) begin
            d_cmd_ready <= 1'b1;
        end else begin
            d_delay <= d_delay - 1;
        end
    end

    task automatic wait_for_store(output logic arrived);
        int cycles;
        cycles = 0;
        while (seen_stores.size() == 0 && cycles < STORE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        arrived = (seen_stores.size() != 0);
    endtask

    task automatic check_field(input string test, input string field,
                               input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("error %s %s: expected %h actual %h", test, field, expected, actual);
            errors++;
        end
    endtask

    initial begin
        store_t got;
        logic   arrived;
        logic   timed_out;
        errors    = 0;
        timed_out = 1'b0;
        reset     = 1'b1;
        for (int k = 0; k < 64; k++) begin
            inst_mem[k] = (k < PROGRAM_LEN) ? program_code[k] : NOP_INST;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        for (int n = 0; n < NUM_STORES && !timed_out; n++) begin
            wait_for_store(arrived);
            if (!arrived) begin
                $display("timeout: store %0d (%s) never reached the data port", n, test_names[n]);
                errors++;
                timed_out = 1'b1;
            end else begin
                got = seen_stores.pop_front();
                check_field(test_names[n], "address", expected_stores[n].addr, got.addr);
                check_field(test_names[n], "mask", word_t'(expected_stores[n].mask),
                            word_t'(got.mask));
                check_field(test_names[n], "data", expected_stores[n].data, got.data);
            end
        end

        // program ends in a self loop, so nothing more may be stored
        if (!timed_out) begin
            repeat (SETTLE_CYCLES) @(negedge clk);
            if (seen_stores.size() != 0) begin
                $display("%0d stores were issued beyond the expected sequence",
                         seen_stores.size());
                errors++;
            end
        end

        $display("store checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module core_tb -f rv_core.f -o core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$log"; then
    exit 1
fi
exit 0

// ==== rv_core.f ====
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/writeback_stage.sv
verilog/core.sv
bench/core_chk.sv
bench/core_tb.sv

// ==== verilog/core.sv ====
`timescale 1ns/100ps

module core
    import core_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic       clk,
    input  logic       reset,
    output logic       inst_start,
    input  logic       inst_ready,
    output word_t      i_addr,
    input  word_t      inst,
    input  logic       inst_valid,
    output logic       d_cmd_start,
    output logic       d_cmd_write,
    input  logic       d_cmd_ready,
    output word_t      d_addr,
    output word_t      wdata,
    output byte_mask_t wmask,
    input  word_t      rdata,
    input  logic       rdata_valid
);

    // stage registers
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;

    // feedback paths
    redirect_t redirect;
    logic      stall;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    //********************
    // front end
    //********************

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (.*);

    decode_stage u_decode (.*);

    execute_stage u_execute (.*);

    //********************
    // back end
    //********************

    memory_stage u_memory (.*);

    // register file lives here, decode reads it
    writeback_stage u_writeback (.*);

endmodule

// ==== verilog/core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_mask_t;

    // ADDI x0,x0,0
    localparam word_t NOP_INST = 32'h0000_0013;

    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_NONE} wb_sel_e;
    typedef enum logic [1:0] {FETCH_IDLE, FETCH_REQUEST, FETCH_WAIT_DATA} fetch_state_e;
    typedef enum logic [1:0] {MEM_IDLE, MEM_COMMAND, MEM_WAIT_DATA} mem_state_e;
    typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE, BR_JAL} branch_e;
    typedef enum logic [1:0] {ST_NONE, ST_WORD, ST_BYTE} store_e;

    //********************
    // stage registers
    //********************

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   alu_op;
        word_t     op1;
        word_t     op2;
        word_t     rs2_data;
        word_t     b_imm;
        branch_e   branch;
        store_e    store;
        logic      load;
        logic      reg_we;
        wb_sel_e   wb_sel;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     alu_result;
        word_t     store_data;
        logic      branch_taken;
        word_t     branch_target;
        store_e    store;
        logic      load;
        logic      reg_we;
        wb_sel_e   wb_sel;
        reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     alu_result;
        word_t     read_data;
        logic      branch_taken;
        word_t     branch_target;
        logic      reg_we;
        wb_sel_e   wb_sel;
        reg_addr_t rd;
    } mem_wb_t;

    typedef struct packed {
        logic  hazard;
        word_t pc;
    } redirect_t;

endpackage

// ==== verilog/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  redirect_t redirect,
    input  logic      stall,
    input  if_id_t    if_id,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output id_ex_t    id_ex
);

    word_t     inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic      funct7_b5;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_j;
    word_t     imm_u;
    logic      supported;
    id_ex_t    dec;

    // bubbles decode as a nop
    assign inst      = if_id.valid ? if_id.inst : NOP_INST;
    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign funct7_b5 = inst[30];
    assign rs1_addr  = inst[19:15];
    assign rs2_addr  = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        dec          = '0;
        dec.pc       = if_id.pc;
        dec.alu_op   = ALU_ADD;
        dec.op1      = rs1_data;
        dec.op2      = rs2_data;
        dec.rs2_data = rs2_data;
        dec.rd       = inst[11:7];
        dec.wb_sel   = WB_ALU;
        dec.branch   = BR_NONE;
        dec.store    = ST_NONE;
        supported    = 1'b1;

        case (opcode)
            OPC_REG, OPC_IMM: begin
                dec.reg_we = 1'b1;
                if (opcode == OPC_IMM) begin
                    dec.op2 = imm_i;
                end
                case (funct3)
                    3'b000: dec.alu_op = (opcode == OPC_REG && funct7_b5) ? ALU_SUB : ALU_ADD;
                    3'b111: dec.alu_op = ALU_AND;
                    3'b110: dec.alu_op = ALU_OR;
                    3'b100: dec.alu_op = ALU_XOR;
                    3'b010: dec.alu_op = ALU_SLT;
                    default: supported = 1'b0;
                endcase
            end
            OPC_LUI: begin
                dec.alu_op = ALU_PASS_B;
                dec.op2    = imm_u;
                dec.reg_we = 1'b1;
            end
            OPC_LOAD: begin
                dec.op2    = imm_i;
                dec.load   = 1'b1;
                dec.reg_we = 1'b1;
                dec.wb_sel = WB_MEM;
                supported  = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                dec.op2    = imm_s;
                dec.wb_sel = WB_NONE;
                case (funct3)
                    3'b010: dec.store = ST_WORD;
                    3'b000: dec.store = ST_BYTE;
                    default: supported = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                dec.b_imm  = imm_b;
                dec.wb_sel = WB_NONE;
                case (funct3)
                    3'b000: dec.branch = BR_BEQ;
                    3'b001: dec.branch = BR_BNE;
                    default: supported = 1'b0;
                endcase
            end
            OPC_JAL: begin
                dec.b_imm  = imm_j;
                dec.branch = BR_JAL;
                dec.reg_we = 1'b1;
                dec.wb_sel = WB_PC4;
            end
            default: supported = 1'b0;
        endcase

        dec.valid = if_id.valid && supported;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex.valid <= 1'b0;
        end else if (redirect.hazard) begin
            id_ex.valid <= 1'b0;
        end else if (!stall) begin
            id_ex <= dec;
        end
    end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  redirect_t redirect,
    input  logic      stall,
    input  id_ex_t    id_ex,
    output ex_mem_t   ex_mem
);

    word_t   alu_result;
    logic    taken;
    ex_mem_t ex_next;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_result = id_ex.op1 + id_ex.op2;
            ALU_SUB:    alu_result = id_ex.op1 - id_ex.op2;
            ALU_AND:    alu_result = id_ex.op1 & id_ex.op2;
            ALU_OR:     alu_result = id_ex.op1 | id_ex.op2;
            ALU_XOR:    alu_result = id_ex.op1 ^ id_ex.op2;
            ALU_SLT:    alu_result = {31'b0, $signed(id_ex.op1) < $signed(id_ex.op2)};
            ALU_PASS_B: alu_result = id_ex.op2;
            default:    alu_result = '0;
        endcase
    end

    // branch compare uses rs1 against rs2
    always_comb begin
        case (id_ex.branch)
            BR_BEQ:  taken = (id_ex.op1 == id_ex.rs2_data);
            BR_BNE:  taken = (id_ex.op1 != id_ex.rs2_data);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign ex_next = '{
        valid:         id_ex.valid,
        pc:            id_ex.pc,
        alu_result:    alu_result,
        store_data:    id_ex.rs2_data,
        branch_taken:  id_ex.valid && taken,
        branch_target: id_ex.pc + id_ex.b_imm,
        store:         id_ex.store,
        load:          id_ex.load,
        reg_we:        id_ex.reg_we,
        wb_sel:        id_ex.wb_sel,
        rd:            id_ex.rd
    };

    always_ff @(posedge clk) begin
        if (reset || redirect.hazard) begin
            ex_mem.valid <= 1'b0;
        end else if (!stall) begin
            ex_mem <= ex_next;
        end
    end

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage
    import core_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      reset,
    input  redirect_t redirect,
    input  logic      stall,
    input  logic      inst_ready,
    input  word_t     inst,
    input  logic      inst_valid,
    output if_id_t    if_id,
    output logic      inst_start,
    output word_t     i_addr
);

    fetch_state_e state;
    word_t        pc;
    word_t        next_pc;
    logic         discard;
    logic         take;
    logic         to_held;
    if_id_t       held;

    // returned instruction that is kept
    assign take = (state == FETCH_WAIT_DATA) && inst_valid && !discard && !redirect.hazard;
    // decode frozen on a valid instruction, park the return
    assign to_held = take && stall && if_id.valid;

    assign next_pc = redirect.hazard ? redirect.pc : (take ? pc + 32'd4 : pc);
    assign inst_start = (state == FETCH_REQUEST);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= FETCH_IDLE;
            pc         <= RESET_PC;
            i_addr     <= RESET_PC;
            discard    <= 1'b0;
            held.valid <= 1'b0;
            if_id.valid <= 1'b0;
        end else begin
            pc <= next_pc;

            if (state == FETCH_WAIT_DATA && inst_valid) begin
                discard <= 1'b0;
            end else if (redirect.hazard && state != FETCH_IDLE) begin
                discard <= 1'b1;
            end

            case (state)
                FETCH_IDLE: begin
                    if (!held.valid || redirect.hazard) begin
                        state  <= FETCH_REQUEST;
                        i_addr <= next_pc;
                    end
                end
                FETCH_REQUEST: begin
                    if (inst_ready) begin
                        state <= FETCH_WAIT_DATA;
                    end
                end
                FETCH_WAIT_DATA: begin
                    if (inst_valid) begin
                        if (to_held) begin
                            state <= FETCH_IDLE;
                        end else begin
                            state  <= FETCH_REQUEST;
                            i_addr <= next_pc;
                        end
                    end
                end
                default: state <= FETCH_IDLE;
            endcase

            // fetch-to-decode register
            if (redirect.hazard) begin
                if_id.valid <= 1'b0;
                held.valid  <= 1'b0;
            end else if (!stall || !if_id.valid) begin
                if (held.valid) begin
                    if_id      <= held;
                    held.valid <= 1'b0;
                end else if (take) begin
                    if_id <= '{1'b1, pc, inst};
                end else begin
                    if_id.valid <= 1'b0;
                end
            end else if (take) begin
                held <= '{1'b1, pc, inst};
            end
        end
    end

endmodule

// ==== verilog/memory_stage.sv ====
`timescale 1ns/100ps

module memory_stage
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  redirect_t  redirect,
    input  ex_mem_t    ex_mem,
    input  logic       d_cmd_ready,
    input  word_t      rdata,
    input  logic       rdata_valid,
    output mem_wb_t    mem_wb,
    output logic       stall,
    output logic       d_cmd_start,
    output logic       d_cmd_write,
    output word_t      d_addr,
    output word_t      wdata,
    output byte_mask_t wmask
);

    mem_state_e state;
    logic       is_mem_op;
    mem_wb_t    wb_next;

    assign is_mem_op = ex_mem.valid && (ex_mem.load || ex_mem.store != ST_NONE);
    assign d_cmd_start = (state == MEM_COMMAND);

    always_comb begin
        case (state)
            MEM_IDLE:      stall = is_mem_op && !redirect.hazard;
            MEM_COMMAND:   stall = !(d_cmd_ready && d_cmd_write);
            MEM_WAIT_DATA: stall = !rdata_valid;
            default:       stall = 1'b0;
        endcase
    end

    // read_data only matters for loads
    assign wb_next = '{
        valid:         ex_mem.valid,
        pc:            ex_mem.pc,
        alu_result:    ex_mem.alu_result,
        read_data:     rdata,
        branch_taken:  ex_mem.branch_taken,
        branch_target: ex_mem.branch_target,
        reg_we:        ex_mem.reg_we,
        wb_sel:        ex_mem.wb_sel,
        rd:            ex_mem.rd
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= MEM_IDLE;
            d_cmd_write  <= 1'b0;
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid <= 1'b0;
            case (state)
                MEM_IDLE: begin
                    if (ex_mem.valid && !redirect.hazard) begin
                        if (is_mem_op) begin
                            state       <= MEM_COMMAND;
                            d_cmd_write <= (ex_mem.store != ST_NONE);
                            d_addr      <= {ex_mem.alu_result[31:2], 2'b00};
                            // sb replicates the byte, one lane enabled
                            if (ex_mem.store == ST_BYTE) begin
                                wdata <= {4{ex_mem.store_data[7:0]}};
                                wmask <= byte_mask_t'(4'b0001 << ex_mem.alu_result[1:0]);
                            end else begin
                                wdata <= ex_mem.store_data;
                                wmask <= 4'b1111;
                            end
                        end else begin
                            mem_wb <= wb_next;
                        end
                    end
                end
                MEM_COMMAND: begin
                    if (d_cmd_ready) begin
                        if (d_cmd_write) begin
                            state  <= MEM_IDLE;
                            mem_wb <= wb_next;
                        end else begin
                            state <= MEM_WAIT_DATA;
                        end
                    end
                end
                MEM_WAIT_DATA: begin
                    if (rdata_valid) begin
                        state  <= MEM_IDLE;
                        mem_wb <= wb_next;
                    end
                end
                default: state <= MEM_IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/writeback_stage.sv ====
`timescale 1ns/100ps

module writeback_stage
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  mem_wb_t   mem_wb,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    output redirect_t redirect
);

    word_t regs [1:31];
    word_t wb_data;

    always_comb begin
        case (mem_wb.wb_sel)
            WB_ALU:  wb_data = mem_wb.alu_result;
            WB_MEM:  wb_data = mem_wb.read_data;
            WB_PC4:  wb_data = mem_wb.pc + 32'd4;
            default: wb_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (mem_wb.valid && mem_wb.reg_we && mem_wb.rd != 5'd0) begin
            regs[mem_wb.rd] <= wb_data;
        end
    end

    // x0 reads zero
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    assign redirect.hazard = mem_wb.valid && mem_wb.branch_taken;
    assign redirect.pc     = mem_wb.branch_target;

endmodule
